//--- list.f
hw/vseq_pkg.sv
hw/vinsn_sequencer.sv
hw/vector_lane.sv
hw/reduction_unit.sv
hw/vector_unit_top.sv
verification/vector_unit_chk.sv
verification/vector_unit_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the vector unit simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module vector_unit_tb -f list.f

out=$(./obj_dir/Vvector_unit_tb)
echo "$out"

# Fails the script unless the pass line was printed
echo "$out" | grep -qx "Test OK"

//--- verification/vector_unit_tb.sv
// Vector unit testbench
`timescale 1ns/10ps

module vector_unit_tb;
  import vseq_pkg::*;

  localparam int unsigned NrLanes    = 4;
  localparam int unsigned MulLatency = 3;
  // Cycles allowed for any single handshake wait
  localparam int Timeout = 200;

  logic  clk_i;
  logic  rst_ni;
  logic  req_i;
  op_e   op_i;
  vreg_t vd_i, vs1_i, vs2_i;
  elem_t scalar_i;
  logic  ack_o;
  elem_t result_o;

  // Reference register file with one element per lane
  elem_t model_regs [NrVReg][NrLanes];

  integer seed;
  int     err_cnt;
  int     chk_cnt;
  int     test_err_start;
  // Set once the handshake stops responding
  logic   hung;

  vector_unit_top #(
    .NrLanes   (NrLanes),
    .MulLatency(MulLatency)
  ) UUT (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (req_i),
    .op_i    (op_i),
    .vd_i    (vd_i),
    .vs1_i   (vs1_i),
    .vs2_i   (vs2_i),
    .scalar_i(scalar_i),
    .ack_o   (ack_o),
    .result_o(result_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic check_value(input string sig, input elem_t got, input elem_t exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("FAILED %s: got %h, expected %h", sig, got, exp);
    end
  endtask

  // Applies one instruction to the model and returns the reduction sum
  task automatic model_step(input op_e op, input vreg_t vd, input vreg_t vs1,
                            input vreg_t vs2, input elem_t scalar, output elem_t sum);
    sum = scalar;
    for (int l = 0; l < NrLanes; l++) begin
      case (op)
        VMV_SX:  model_regs[vd][l] = scalar;
        VID:     model_regs[vd][l] = elem_t'(l);
        VADD_VV: model_regs[vd][l] = model_regs[vs2][l] + model_regs[vs1][l];
        VXOR_VV: model_regs[vd][l] = model_regs[vs2][l] ^ model_regs[vs1][l];
        VADD_VX: model_regs[vd][l] = model_regs[vs2][l] + scalar;
        // Product truncated to the element width
        VMUL_VV: model_regs[vd][l] = model_regs[vs1][l] * model_regs[vs2][l];
        default: sum = sum + model_regs[vs2][l];
      endcase
    end
  endtask

  // Full four-phase handshake for one instruction
  task automatic send(input op_e op, input vreg_t vd, input vreg_t vs1,
                      input vreg_t vs2, input elem_t scalar, output elem_t res);
    int cnt;
    res = '0;
    if (hung) return;
    op_i     = op;
    vd_i     = vd;
    vs1_i    = vs1;
    vs2_i    = vs2;
    scalar_i = scalar;
    req_i    = 1'b1;
    cnt      = 0;
    while (!ack_o && cnt < Timeout) begin
      @(posedge clk_i);
      #1;
      cnt++;
    end
    if (!ack_o) begin
      err_cnt++;
      hung  = 1'b1;
      req_i = 1'b0;
      $display("Timeout while waiting for ack to rise, op %s", op.name());
      return;
    end
    res   = result_o;
    req_i = 1'b0;
    cnt   = 0;
    while (ack_o && cnt < Timeout) begin
      @(posedge clk_i);
      #1;
      cnt++;
    end
    if (ack_o) begin
      err_cnt++;
      hung = 1'b1;
      $display("Timeout while waiting for ack to fall, op %s", op.name());
    end
  endtask

  // Sends one instruction and checks a reduction result
  task automatic exec(input op_e op, input vreg_t vd, input vreg_t vs1,
                      input vreg_t vs2, input elem_t scalar);
    elem_t exp_sum;
    elem_t res;
    model_step(op, vd, vs1, vs2, scalar, exp_sum);
    send(op, vd, vs1, vs2, scalar, res);
    if (op == VREDSUM && !hung) check_value("result_o", res, exp_sum);
  endtask

  task automatic report_test(input string name);
    $display("%s done, %0d errors", name, err_cnt - test_err_start);
    test_err_start = err_cnt;
  endtask

  task automatic reset_handshake();
    check_value("ack_o", elem_t'(ack_o), '0);
    exec(VMV_SX, 3'd0, 3'd0, 3'd0, 32'h0000_00a5);
    // Reading v0 back shows the first instruction took effect
    exec(VREDSUM, 3'd0, 3'd0, 3'd0, 32'h0000_0000);
    report_test("reset_hs");
  endtask

  task automatic broadcast_sum();
    exec(VMV_SX, 3'd1, 3'd0, 3'd0, 32'h1234_5678);
    exec(VREDSUM, 3'd0, 3'd0, 3'd1, 32'h0000_0011);
    report_test("broadcast_sum");
  endtask

  // Back-to-back dependent ALU ops
  task automatic raw_alu_chain();
    exec(VID, 3'd2, 3'd0, 3'd0, '0);
    exec(VADD_VV, 3'd3, 3'd2, 3'd2, '0);
    exec(VREDSUM, 3'd0, 3'd0, 3'd3, 32'h0000_0005);
    report_test("raw_alu");
  endtask

  // Slow multiply overtaken by a fast add to the same register
  task automatic waw_mul_overtake();
    exec(VMUL_VV, 3'd4, 3'd2, 3'd2, '0);
    exec(VADD_VV, 3'd4, 3'd3, 3'd3, '0);
    exec(VREDSUM, 3'd0, 3'd0, 3'd4, 32'h0000_0007);
    exec(VMUL_VV, 3'd6, 3'd3, 3'd4, '0);
    exec(VREDSUM, 3'd0, 3'd0, 3'd6, 32'h0000_0100);
    report_test("waw_mul");
  endtask

  task automatic war_reuse();
    exec(VADD_VX, 3'd5, 3'd0, 3'd2, 32'h0000_0064);
    exec(VREDSUM, 3'd0, 3'd0, 3'd5, 32'h0000_0003);
    exec(VXOR_VV, 3'd5, 3'd3, 3'd5, '0);
    exec(VREDSUM, 3'd0, 3'd0, 3'd5, 32'h0000_0009);
    report_test("war");
  endtask

  task automatic random_stream();
    logic [31:0] r;
    logic [15:0] sel;
    // Give every register a defined value first
    for (int v = 0; v < NrVReg; v++) begin
      r = $random(seed);
      exec(VMV_SX, vreg_t'(v), 3'd0, 3'd0, r);
    end
    for (int i = 0; i < 20; i++) begin
      r   = $random(seed);
      sel = r[15:0] % 16'd7;
      exec(op_e'(sel[2:0]), r[18:16], r[21:19], r[24:22], $random(seed));
    end
    // Reduce every register to compare the whole model state
    for (int v = 0; v < NrVReg; v++) begin
      exec(VREDSUM, 3'd0, 3'd0, vreg_t'(v), '0);
    end
    report_test("random");
  endtask

  initial begin
    seed           = 32'h774afd99;
    err_cnt        = 0;
    chk_cnt        = 0;
    test_err_start = 0;
    hung           = 1'b0;
    rst_ni         = 1'b0;
    req_i          = 1'b0;
    op_i           = VMV_SX;
    vd_i           = '0;
    vs1_i          = '0;
    vs2_i          = '0;
    scalar_i       = '0;
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    reset_handshake();
    broadcast_sum();
    raw_alu_chain();
    waw_mul_overtake();
    war_reuse();
    random_stream();
    $display("Checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- verification/vector_unit_chk.sv
// Sequencer protocol assertions
`timescale 1ns/10ps

module vector_unit_chk import vseq_pkg::*; (
  input logic   clk_i,
  input logic   rst_ni,
  input logic   req_i,
  input logic   ack_i,
  input logic   pe_valid_i,
  input vid_t   pe_id_i,
  input vmask_t running_i,
  input logic   lanes_ready_i,
  input logic   red_ready_i
);

  // Ack held until the dispatcher lets go
  ack_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ack_i && req_i) |=> ack_i)
    else $error("ack dropped while req still high");

  // No ack without a request
  ack_no_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (!ack_i && !req_i) |=> !ack_i)
    else $error("ack raised without req");

  pe_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pe_valid_i |-> (lanes_ready_i && red_ready_i))
    else $error("broadcast while an element was busy");

  // Issued id was free one cycle earlier
  pe_id_free: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pe_valid_i |-> !(|($past(running_i) & (vmask_t'(1) << pe_id_i))))
    else $error("broadcast reused a running id");

endmodule

bind vinsn_sequencer vector_unit_chk i_chk (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .req_i        (req_i),
  .ack_i        (ack_o),
  .pe_valid_i   (pe_valid_o),
  .pe_id_i      (pe_id_o),
  .running_i    (running_o),
  .lanes_ready_i(&lane_ready_i),
  .red_ready_i  (red_ready_i)
);

//--- hw/vector_unit_top.sv
// Vector unit top level
`timescale 1ns/10ps

module vector_unit_top import vseq_pkg::*; #(
  parameter int unsigned NrLanes    = 4,
  parameter int unsigned MulLatency = 3
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  // Dispatcher handshake
  input  logic  req_i,
  input  op_e   op_i,
  input  vreg_t vd_i,
  input  vreg_t vs1_i,
  input  vreg_t vs2_i,
  input  elem_t scalar_i,
  output logic  ack_o,
  output elem_t result_o
);

  // Request broadcast
  logic   pe_valid;
  vid_t   pe_id;
  op_e    pe_op;
  vreg_t  pe_vd, pe_vs1, pe_vs2;
  elem_t  pe_scalar;
  vmask_t pe_hz_vs1, pe_hz_vs2, pe_hz_vd;
  vmask_t running;

  // Lane returns
  logic [NrLanes-1:0]   lane_ready;
  vmask_t [NrLanes-1:0] lane_done;
  elem_t [NrLanes-1:0]  lane_part;
  logic [NrLanes-1:0]   lane_part_valid;

  // Reduction returns
  logic   red_ready;
  vmask_t red_done;
  elem_t  red_sum;
  logic   red_sum_valid;

  vinsn_sequencer #(
    .NrLanes(NrLanes)
  ) i_sequencer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .op_i           (op_i),
    .vd_i           (vd_i),
    .vs1_i          (vs1_i),
    .vs2_i          (vs2_i),
    .scalar_i       (scalar_i),
    .ack_o          (ack_o),
    .result_o       (result_o),
    .pe_valid_o     (pe_valid),
    .pe_id_o        (pe_id),
    .pe_op_o        (pe_op),
    .pe_vd_o        (pe_vd),
    .pe_vs1_o       (pe_vs1),
    .pe_vs2_o       (pe_vs2),
    .pe_scalar_o    (pe_scalar),
    .pe_hz_vs1_o    (pe_hz_vs1),
    .pe_hz_vs2_o    (pe_hz_vs2),
    .pe_hz_vd_o     (pe_hz_vd),
    .running_o      (running),
    .lane_ready_i   (lane_ready),
    .lane_done_i    (lane_done),
    .red_ready_i    (red_ready),
    .red_done_i     (red_done),
    .red_sum_i      (red_sum),
    .red_sum_valid_i(red_sum_valid)
  );

  // One lane per element index
  for (genvar l = 0; l < NrLanes; l++) begin : gen_lane
    vector_lane #(
      .LaneIdx   (l),
      .MulLatency(MulLatency)
    ) i_lane (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .pe_valid_i  (pe_valid),
      .pe_id_i     (pe_id),
      .pe_op_i     (pe_op),
      .pe_vd_i     (pe_vd),
      .pe_vs1_i    (pe_vs1),
      .pe_vs2_i    (pe_vs2),
      .pe_scalar_i (pe_scalar),
      .pe_hz_vs1_i (pe_hz_vs1),
      .pe_hz_vs2_i (pe_hz_vs2),
      .pe_hz_vd_i  (pe_hz_vd),
      .running_i   (running),
      .ready_o     (lane_ready[l]),
      .done_o      (lane_done[l]),
      .part_o      (lane_part[l]),
      .part_valid_o(lane_part_valid[l])
    );
  end

  reduction_unit #(
    .NrLanes(NrLanes)
  ) i_reduction (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .pe_valid_i  (pe_valid),
    .pe_id_i     (pe_id),
    .pe_op_i     (pe_op),
    .pe_scalar_i (pe_scalar),
    .part_i      (lane_part),
    .part_valid_i(lane_part_valid),
    .ready_o     (red_ready),
    .done_o      (red_done),
    .sum_o       (red_sum),
    .sum_valid_o (red_sum_valid)
  );

endmodule

//--- hw/reduction_unit.sv
// Sum reduction unit
`timescale 1ns/10ps

module reduction_unit import vseq_pkg::*; #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Request broadcast, only VREDSUM matters here
  input  logic                 pe_valid_i,
  input  vid_t                 pe_id_i,
  input  op_e                  pe_op_i,
  input  elem_t                pe_scalar_i,
  // Lane partials
  input  elem_t [NrLanes-1:0]  part_i,
  input  logic [NrLanes-1:0]   part_valid_i,
  output logic                 ready_o,
  output vmask_t               done_o,
  output elem_t                sum_o,
  output logic                 sum_valid_o
);

  logic               start, all_in;
  logic               busy_q, sum_valid_q;
  logic [NrLanes-1:0] arrived_d, arrived_q;
  vid_t               id_q;
  elem_t              acc_d, acc_q;
  vmask_t             done_d, done_q;

  assign start = pe_valid_i && (pe_op_i == VREDSUM);

  // Add this cycle's partials, sum wraps at 32 bits
  always_comb begin : p_accumulate
    acc_d     = acc_q;
    arrived_d = arrived_q;
    for (int unsigned l = 0; l < NrLanes; l++) begin
      if (part_valid_i[l]) begin
        acc_d        = acc_d + part_i[l];
        arrived_d[l] = 1'b1;
      end
    end
  end

  assign all_in = busy_q && (&arrived_d);

  always_comb begin : p_done
    done_d = '0;
    if (all_in) done_d[id_q] = 1'b1;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl_ff
    if (!rst_ni) begin
      busy_q      <= 1'b0;
      arrived_q   <= '0;
      sum_valid_q <= 1'b0;
      done_q      <= '0;
    end else begin
      if (start) begin
        busy_q    <= 1'b1;
        arrived_q <= '0;
      end else if (all_in) begin
        busy_q    <= 1'b0;
        arrived_q <= '0;
      end else begin
        arrived_q <= arrived_d;
      end
      sum_valid_q <= all_in;
      done_q      <= done_d;
    end
  end

  // Accumulator seeded with the scalar operand, held after completion
  always_ff @(posedge clk_i) begin : p_data_ff
    if (start) begin
      id_q  <= pe_id_i;
      acc_q <= pe_scalar_i;
    end else if (busy_q) begin
      acc_q <= acc_d;
    end
  end

  assign ready_o     = !busy_q;
  assign done_o      = done_q;
  assign sum_o       = acc_q;
  assign sum_valid_o = sum_valid_q;

endmodule

//--- hw/vector_lane.sv
// Vector lane
`timescale 1ns/10ps

module vector_lane import vseq_pkg::*; #(
  parameter int unsigned LaneIdx    = 0,
  parameter int unsigned MulLatency = 3
) (
  input  logic   clk_i,
  input  logic   rst_ni,
  // Request broadcast
  input  logic   pe_valid_i,
  input  vid_t   pe_id_i,
  input  op_e    pe_op_i,
  input  vreg_t  pe_vd_i,
  input  vreg_t  pe_vs1_i,
  input  vreg_t  pe_vs2_i,
  input  elem_t  pe_scalar_i,
  input  vmask_t pe_hz_vs1_i,
  input  vmask_t pe_hz_vs2_i,
  input  vmask_t pe_hz_vd_i,
  input  vmask_t running_i,
  output logic   ready_o,
  output vmask_t done_o,
  // Partial sum toward the reduction unit
  output elem_t  part_o,
  output logic   part_valid_o
);

  // This lane's slice of the register file
  elem_t vreg_q [NrVReg];

  // Issue register
  logic   iq_valid_q;
  vid_t   iq_id_q;
  op_e    iq_op_q;
  vreg_t  iq_vd_q, iq_vs1_q, iq_vs2_q;
  elem_t  iq_scalar_q;
  vmask_t iq_hz_q;

  logic  iq_is_mul, path_free, hz_clear, release_insn;
  elem_t opa, opb, alu_res;

  // Single ALU stage
  logic  alu_valid_q, alu_red_q;
  vid_t  alu_id_q;
  vreg_t alu_vd_q;
  elem_t alu_res_q;

  // Multiplier pipeline
  logic [MulLatency-1:0] mul_valid_q;
  vid_t  mul_id_q  [MulLatency];
  vreg_t mul_vd_q  [MulLatency];
  elem_t mul_res_q [MulLatency];

  vmask_t done_d, done_q;

  assign ready_o   = !iq_valid_q;
  assign iq_is_mul = (iq_op_q == VMUL_VV);
  // Only one op per path in flight
  assign path_free = iq_is_mul ? !(|mul_valid_q) : !alu_valid_q;
  // Wait until every id we depend on has finished everywhere
  assign hz_clear     = !(|(iq_hz_q & running_i));
  assign release_insn = iq_valid_q && hz_clear && path_free;

  assign opa = vreg_q[iq_vs1_q];
  assign opb = vreg_q[iq_vs2_q];

  always_comb begin : p_alu
    case (iq_op_q)
      VMV_SX:  alu_res = iq_scalar_q;
      VID:     alu_res = elem_t'(LaneIdx);
      VADD_VV: alu_res = opb + opa;
      VXOR_VV: alu_res = opb ^ opa;
      VADD_VX: alu_res = opb + iq_scalar_q;
      // VREDSUM forwards its vs2 element as partial
      default: alu_res = opb;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl_ff
    if (!rst_ni) begin
      iq_valid_q  <= 1'b0;
      alu_valid_q <= 1'b0;
      alu_red_q   <= 1'b0;
      mul_valid_q <= '0;
      done_q      <= '0;
    end else begin
      if (pe_valid_i) iq_valid_q <= 1'b1;
      else if (release_insn) iq_valid_q <= 1'b0;
      alu_valid_q    <= release_insn && !iq_is_mul;
      alu_red_q      <= release_insn && (iq_op_q == VREDSUM);
      mul_valid_q[0] <= release_insn && iq_is_mul;
      for (int s = 1; s < MulLatency; s++) begin
        mul_valid_q[s] <= mul_valid_q[s-1];
      end
      done_q <= done_d;
    end
  end

  always_ff @(posedge clk_i) begin : p_data_ff
    if (pe_valid_i) begin
      iq_id_q     <= pe_id_i;
      iq_op_q     <= pe_op_i;
      iq_vd_q     <= pe_vd_i;
      iq_vs1_q    <= pe_vs1_i;
      iq_vs2_q    <= pe_vs2_i;
      iq_scalar_q <= pe_scalar_i;
      // The lane gates on the union of all three masks
      iq_hz_q     <= pe_hz_vs1_i | pe_hz_vs2_i | pe_hz_vd_i;
    end
    alu_id_q  <= iq_id_q;
    alu_vd_q  <= iq_vd_q;
    alu_res_q <= alu_res;
    mul_id_q[0]  <= iq_id_q;
    mul_vd_q[0]  <= iq_vd_q;
    // Low 32 bits of the product
    mul_res_q[0] <= opa * opb;
    for (int s = 1; s < MulLatency; s++) begin
      mul_id_q[s]  <= mul_id_q[s-1];
      mul_vd_q[s]  <= mul_vd_q[s-1];
      mul_res_q[s] <= mul_res_q[s-1];
    end
    // Both paths may write in the same cycle to different registers
    if (alu_valid_q && !alu_red_q) vreg_q[alu_vd_q] <= alu_res_q;
    if (mul_valid_q[MulLatency-1]) begin
      vreg_q[mul_vd_q[MulLatency-1]] <= mul_res_q[MulLatency-1];
    end
  end

  // Completion one cycle after the write or the partial handover
  always_comb begin : p_done
    done_d = '0;
    if (alu_valid_q) done_d[alu_id_q] = 1'b1;
    if (mul_valid_q[MulLatency-1]) done_d[mul_id_q[MulLatency-1]] = 1'b1;
  end

  assign done_o       = done_q;
  assign part_o       = alu_res_q;
  assign part_valid_o = alu_valid_q && alu_red_q;

endmodule

//--- hw/vinsn_sequencer.sv
// Vector instruction sequencer
`timescale 1ns/10ps

module vinsn_sequencer import vseq_pkg::*; #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Dispatcher, four-phase req/ack
  input  logic                 req_i,
  input  op_e                  op_i,
  input  vreg_t                vd_i,
  input  vreg_t                vs1_i,
  input  vreg_t                vs2_i,
  input  elem_t                scalar_i,
  output logic                 ack_o,
  output elem_t                result_o,
  // Request broadcast to the processing elements
  output logic                 pe_valid_o,
  output vid_t                 pe_id_o,
  output op_e                  pe_op_o,
  output vreg_t                pe_vd_o,
  output vreg_t                pe_vs1_o,
  output vreg_t                pe_vs2_o,
  output elem_t                pe_scalar_o,
  output vmask_t               pe_hz_vs1_o,
  output vmask_t               pe_hz_vs2_o,
  output vmask_t               pe_hz_vd_o,
  output vmask_t               running_o,
  // Lane feedback
  input  logic [NrLanes-1:0]   lane_ready_i,
  input  vmask_t [NrLanes-1:0] lane_done_i,
  // Reduction unit feedback
  input  logic                 red_ready_i,
  input  vmask_t               red_done_i,
  input  elem_t                red_sum_i,
  input  logic                 red_sum_valid_i
);

  // Lanes first, reduction unit last
  localparam int unsigned NrPEs = NrLanes + 1;

  // Running ids per processing element
  vmask_t [NrPEs-1:0] pe_running_d, pe_running_q;
  vmask_t [NrPEs-1:0] pe_done;

  vid_t       next_id;
  logic       id_free;
  logic       issue;
  seq_state_e state_d, state_q;
  logic       ack_d, ack_q;
  elem_t      result_d, result_q;

  // Last reader and last writer of each vector register
  vid_t [NrVReg-1:0] rd_id_d, rd_id_q, wr_id_d, wr_id_q;
  logic [NrVReg-1:0] rd_vld_d, rd_vld_q, wr_vld_d, wr_vld_q;
  vmask_t            hz_vs1_d, hz_vs2_d, hz_vd_d;

  // Registered broadcast
  logic   pe_valid_q;
  vid_t   pe_id_q;
  op_e    pe_op_q;
  vreg_t  pe_vd_q, pe_vs1_q, pe_vs2_q;
  elem_t  pe_scalar_q;
  vmask_t pe_hz_vs1_q, pe_hz_vs2_q, pe_hz_vd_q;

  assign pe_done = {red_done_i, lane_done_i};

  always_comb begin : p_running
    running_o = '0;
    for (int unsigned p = 0; p < NrPEs; p++) begin
      running_o |= pe_running_q[p];
    end
  end

  // Lowest free id, the last hit of a downward scan wins
  always_comb begin : p_next_id
    next_id = '0;
    id_free = 1'b0;
    for (int i = NrVInsn - 1; i >= 0; i--) begin
      if (!running_o[i]) begin
        next_id = vid_t'(i);
        id_free = 1'b1;
      end
    end
  end

  // Every element must be able to take the request
  assign issue = (state_q == ISSUE) && (&lane_ready_i) && red_ready_i && id_free;

  always_comb begin : p_hazards
    rd_id_d  = rd_id_q;
    wr_id_d  = wr_id_q;
    hz_vs1_d = '0;
    hz_vs2_d = '0;
    hz_vd_d  = '0;
    // Drop entries whose instruction is gone
    for (int v = 0; v < NrVReg; v++) begin
      rd_vld_d[v] = rd_vld_q[v] & running_o[rd_id_q[v]];
      wr_vld_d[v] = wr_vld_q[v] & running_o[wr_id_q[v]];
    end
    // RAW on the sources
    if (uses_vs1(op_i) && wr_vld_d[vs1_i]) hz_vs1_d[wr_id_d[vs1_i]] = 1'b1;
    if (uses_vs2(op_i) && wr_vld_d[vs2_i]) hz_vs2_d[wr_id_d[vs2_i]] = 1'b1;
    if (uses_vd(op_i)) begin
      // WAR, wait for the last reader of vd
      if (rd_vld_d[vd_i]) begin
        hz_vs1_d[rd_id_d[vd_i]] = 1'b1;
        hz_vs2_d[rd_id_d[vd_i]] = 1'b1;
      end
      // WAW
      if (wr_vld_d[vd_i]) hz_vd_d[wr_id_d[vd_i]] = 1'b1;
    end
    // Record the new access after the masks are built
    if (issue) begin
      if (uses_vd(op_i)) begin
        wr_id_d[vd_i]  = next_id;
        wr_vld_d[vd_i] = 1'b1;
      end
      if (uses_vs1(op_i)) begin
        rd_id_d[vs1_i]  = next_id;
        rd_vld_d[vs1_i] = 1'b1;
      end
      if (uses_vs2(op_i)) begin
        rd_id_d[vs2_i]  = next_id;
        rd_vld_d[vs2_i] = 1'b1;
      end
    end
  end

  always_comb begin : p_running_next
    for (int unsigned p = 0; p < NrPEs; p++) begin
      pe_running_d[p] = pe_running_q[p] & ~pe_done[p];
    end
    if (issue) begin
      // Every op touches all lanes
      for (int unsigned l = 0; l < NrLanes; l++) begin
        pe_running_d[l][next_id] = 1'b1;
      end
      if (op_i == VREDSUM) pe_running_d[NrLanes][next_id] = 1'b1;
    end
  end

  always_comb begin : p_fsm
    state_d  = state_q;
    ack_d    = ack_q;
    result_d = result_q;
    case (state_q)
      IDLE: begin
        if (req_i) state_d = ISSUE;
      end
      ISSUE: begin
        // Stays here under back-pressure
        if (issue) state_d = (op_i == VREDSUM) ? WAIT_SCALAR : ACKED;
      end
      WAIT_SCALAR: begin
        if (red_sum_valid_i) begin
          result_d = red_sum_i;
          ack_d    = 1'b1;
          state_d  = ACKED;
        end
      end
      ACKED: begin
        // First cycle here follows the broadcast pulse
        if (!ack_q) begin
          ack_d = 1'b1;
        end else if (!req_i) begin
          ack_d   = 1'b0;
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl_ff
    if (!rst_ni) begin
      state_q      <= IDLE;
      ack_q        <= 1'b0;
      pe_valid_q   <= 1'b0;
      pe_running_q <= '0;
      rd_vld_q     <= '0;
      wr_vld_q     <= '0;
    end else begin
      state_q      <= state_d;
      ack_q        <= ack_d;
      pe_valid_q   <= issue;
      pe_running_q <= pe_running_d;
      rd_vld_q     <= rd_vld_d;
      wr_vld_q     <= wr_vld_d;
    end
  end

  always_ff @(posedge clk_i) begin : p_data_ff
    result_q <= result_d;
    rd_id_q  <= rd_id_d;
    wr_id_q  <= wr_id_d;
    if (issue) begin
      pe_id_q     <= next_id;
      pe_op_q     <= op_i;
      pe_vd_q     <= vd_i;
      pe_vs1_q    <= vs1_i;
      pe_vs2_q    <= vs2_i;
      pe_scalar_q <= scalar_i;
      pe_hz_vs1_q <= hz_vs1_d;
      pe_hz_vs2_q <= hz_vs2_d;
      pe_hz_vd_q  <= hz_vd_d;
    end
  end

  assign ack_o       = ack_q;
  assign result_o    = result_q;
  assign pe_valid_o  = pe_valid_q;
  assign pe_id_o     = pe_id_q;
  assign pe_op_o     = pe_op_q;
  assign pe_vd_o     = pe_vd_q;
  assign pe_vs1_o    = pe_vs1_q;
  assign pe_vs2_o    = pe_vs2_q;
  assign pe_scalar_o = pe_scalar_q;
  assign pe_hz_vs1_o = pe_hz_vs1_q;
  assign pe_hz_vs2_o = pe_hz_vs2_q;
  assign pe_hz_vd_o  = pe_hz_vd_q;

endmodule

//--- hw/vseq_pkg.sv
// Vector sequencer package

package vseq_pkg;

  // Register file geometry
  localparam int NrVReg  = 8;
  // Instructions in flight at once
  localparam int NrVInsn = 4;

  // One 32-bit element, also used for scalar operands and results
  typedef logic [31:0] elem_t;
  // Vector register index
  typedef logic [2:0] vreg_t;
  // Instruction id
  typedef logic [1:0] vid_t;
  // One bit per instruction id
  typedef logic [NrVInsn-1:0] vmask_t;

  // Supported vector operations
  typedef enum logic [2:0] {
    VMV_SX,
    VID,
    VADD_VV,
    VXOR_VV,
    VADD_VX,
    VMUL_VV,
    VREDSUM
  } op_e;

  // Sequencer handshake states
  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    WAIT_SCALAR,
    ACKED
  } seq_state_e;

  // Op reads vs1
  function automatic logic uses_vs1(op_e op);
    return (op == VADD_VV) || (op == VXOR_VV) || (op == VMUL_VV);
  endfunction

  // Op reads vs2
  function automatic logic uses_vs2(op_e op);
    return (op == VADD_VV) || (op == VXOR_VV) || (op == VADD_VX) ||
           (op == VMUL_VV) || (op == VREDSUM);
  endfunction

  // Op writes vd, the reduction answers with a scalar instead
  function automatic logic uses_vd(op_e op);
    return op != VREDSUM;
  endfunction

endpackage
